//--- verilog/axi_pkg.sv
package axi_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // read address
  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  // write address
  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;  // byte enables
  } w_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

endpackage

//--- verilog/soc_map_pkg.sv
package soc_map_pkg;

  localparam axi_pkg::addr_t CLINT_BASE_DEFAULT = 32'ha000_0000;
  localparam axi_pkg::addr_t CLINT_SIZE         = 32'h100;

  // mtime word offsets inside the clint window
  localparam logic [7:0] MTIME_LO_OFFSET = 8'h48;
  localparam logic [7:0] MTIME_HI_OFFSET = 8'h4c;

  typedef logic [0:0] master_id_t;  // 0 fetch, 1 load/store

  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_CLINT,
    ROUTE_EXT
  } route_t;

endpackage

//--- verilog/axi_arbiter.sv
`timescale 1ns/10ps

module axi_arbiter (
  input  logic              clock,
  input  logic              reset,
  // master 0, instruction fetch
  input  logic              ar_valid_0,
  input  axi_pkg::ar_chan_t ar_0,
  output logic              ar_ready_0,
  output logic              r_valid_0,
  output axi_pkg::r_chan_t  r_0,
  input  logic              r_ready_0,
  input  logic              aw_valid_0,
  input  axi_pkg::aw_chan_t aw_0,
  output logic              aw_ready_0,
  input  logic              w_valid_0,
  input  axi_pkg::w_chan_t  w_0,
  output logic              w_ready_0,
  output logic              b_valid_0,
  output axi_pkg::b_chan_t  b_0,
  input  logic              b_ready_0,
  // master 1, load/store
  input  logic              ar_valid_1,
  input  axi_pkg::ar_chan_t ar_1,
  output logic              ar_ready_1,
  output logic              r_valid_1,
  output axi_pkg::r_chan_t  r_1,
  input  logic              r_ready_1,
  input  logic              aw_valid_1,
  input  axi_pkg::aw_chan_t aw_1,
  output logic              aw_ready_1,
  input  logic              w_valid_1,
  input  axi_pkg::w_chan_t  w_1,
  output logic              w_ready_1,
  output logic              b_valid_1,
  output axi_pkg::b_chan_t  b_1,
  input  logic              b_ready_1,
  // granted set
  output logic              g_ar_valid,
  output axi_pkg::ar_chan_t g_ar,
  input  logic              g_ar_ready,
  input  logic              g_r_valid,
  input  axi_pkg::r_chan_t  g_r,
  output logic              g_r_ready,
  output logic              g_aw_valid,
  output axi_pkg::aw_chan_t g_aw,
  input  logic              g_aw_ready,
  output logic              g_w_valid,
  output axi_pkg::w_chan_t  g_w,
  input  logic              g_w_ready,
  input  logic              g_b_valid,
  input  axi_pkg::b_chan_t  g_b,
  output logic              g_b_ready
);
  import soc_map_pkg::*;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_WRITE
  } arb_state_t;

  arb_state_t state;
  master_id_t gnt;   // doubles as last granted once the bus is idle again
  master_id_t pick;
  logic [1:0] rd_req, wr_req, req;
  logic       rd_0, rd_1, wr_0, wr_1;
  logic       addr_done, data_done;
  logic       done;

  assign rd_req = {ar_valid_1, ar_valid_0};
  assign wr_req = {aw_valid_1 & w_valid_1, aw_valid_0 & w_valid_0};
  assign req    = rd_req | wr_req;
  assign pick   = (req[0] && req[1]) ? ~gnt : req[1];  // tie goes to the other one

  assign rd_0 = (state == ARB_READ) && (gnt == 1'b0);
  assign rd_1 = (state == ARB_READ) && (gnt == 1'b1);
  assign wr_0 = (state == ARB_WRITE) && (gnt == 1'b0);
  assign wr_1 = (state == ARB_WRITE) && (gnt == 1'b1);

  assign done = (state == ARB_READ && g_r_valid && g_r_ready) ||
                (state == ARB_WRITE && g_b_valid && g_b_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ARB_IDLE;
      gnt       <= 1'b0;
      addr_done <= 1'b0;
      data_done <= 1'b0;
    end else if (state == ARB_IDLE) begin
      if (|req) begin
        gnt   <= pick;
        state <= rd_req[pick] ? ARB_READ : ARB_WRITE;  // read first
      end
    end else if (done) begin
      state     <= ARB_IDLE;
      addr_done <= 1'b0;
      data_done <= 1'b0;
    end else begin
      if ((g_ar_valid && g_ar_ready) || (g_aw_valid && g_aw_ready))
        addr_done <= 1'b1;
      if (g_w_valid && g_w_ready)
        data_done <= 1'b1;
    end
  end

  // downstream mux where each channel closes after its own handshake
  assign g_ar_valid = ((rd_0 && ar_valid_0) || (rd_1 && ar_valid_1)) && !addr_done;
  assign g_ar       = rd_0 ? ar_0 : (rd_1 ? ar_1 : '0);
  assign g_r_ready  = (rd_0 && r_ready_0) || (rd_1 && r_ready_1);
  assign g_aw_valid = ((wr_0 && aw_valid_0) || (wr_1 && aw_valid_1)) && !addr_done;
  assign g_aw       = wr_0 ? aw_0 : (wr_1 ? aw_1 : '0);
  assign g_w_valid  = ((wr_0 && w_valid_0) || (wr_1 && w_valid_1)) && !data_done;
  assign g_w        = wr_0 ? w_0 : (wr_1 ? w_1 : '0);
  assign g_b_ready  = (wr_0 && b_ready_0) || (wr_1 && b_ready_1);

  assign ar_ready_0 = rd_0 && !addr_done && g_ar_ready;
  assign r_valid_0  = rd_0 && g_r_valid;
  assign r_0        = rd_0 ? g_r : '0;
  assign aw_ready_0 = wr_0 && !addr_done && g_aw_ready;
  assign w_ready_0  = wr_0 && !data_done && g_w_ready;
  assign b_valid_0  = wr_0 && g_b_valid;
  assign b_0        = wr_0 ? g_b : '0;

  assign ar_ready_1 = rd_1 && !addr_done && g_ar_ready;
  assign r_valid_1  = rd_1 && g_r_valid;
  assign r_1        = rd_1 ? g_r : '0;
  assign aw_ready_1 = wr_1 && !addr_done && g_aw_ready;
  assign w_ready_1  = wr_1 && !data_done && g_w_ready;
  assign b_valid_1  = wr_1 && g_b_valid;
  assign b_1        = wr_1 ? g_b : '0;

  // a slave only answers the kind of transaction that holds the grant
  a_resp_matches_grant: assert property (@(posedge clock) disable iff (reset)
    (g_r_valid |-> state == ARB_READ) and (g_b_valid |-> state == ARB_WRITE));

  // no stale response left over when the next grant is taken
  a_resp_after_addr: assert property (@(posedge clock) disable iff (reset)
    (g_r_valid |-> addr_done) and (g_b_valid |-> addr_done && data_done));

endmodule

//--- verilog/axi_addr_router.sv
`timescale 1ns/10ps

module axi_addr_router #(
  parameter axi_pkg::addr_t clint_base = soc_map_pkg::CLINT_BASE_DEFAULT
) (
  input  logic              clock,
  input  logic              reset,
  // granted set from the arbiter
  input  logic              g_ar_valid,
  input  axi_pkg::ar_chan_t g_ar,
  output logic              g_ar_ready,
  output logic              g_r_valid,
  output axi_pkg::r_chan_t  g_r,
  input  logic              g_r_ready,
  input  logic              g_aw_valid,
  input  axi_pkg::aw_chan_t g_aw,
  output logic              g_aw_ready,
  input  logic              g_w_valid,
  input  axi_pkg::w_chan_t  g_w,
  output logic              g_w_ready,
  output logic              g_b_valid,
  output axi_pkg::b_chan_t  g_b,
  input  logic              g_b_ready,
  // clint
  output logic              c_ar_valid,
  output axi_pkg::ar_chan_t c_ar,
  input  logic              c_ar_ready,
  input  logic              c_r_valid,
  input  axi_pkg::r_chan_t  c_r,
  output logic              c_r_ready,
  output logic              c_aw_valid,
  output axi_pkg::aw_chan_t c_aw,
  input  logic              c_aw_ready,
  output logic              c_w_valid,
  output axi_pkg::w_chan_t  c_w,
  input  logic              c_w_ready,
  input  logic              c_b_valid,
  input  axi_pkg::b_chan_t  c_b,
  output logic              c_b_ready,
  // external port
  output logic              e_ar_valid,
  output axi_pkg::ar_chan_t e_ar,
  input  logic              e_ar_ready,
  input  logic              e_r_valid,
  input  axi_pkg::r_chan_t  e_r,
  output logic              e_r_ready,
  output logic              e_aw_valid,
  output axi_pkg::aw_chan_t e_aw,
  input  logic              e_aw_ready,
  output logic              e_w_valid,
  output axi_pkg::w_chan_t  e_w,
  input  logic              e_w_ready,
  input  logic              e_b_valid,
  input  axi_pkg::b_chan_t  e_b,
  output logic              e_b_ready
);
  import axi_pkg::*;
  import soc_map_pkg::*;

  addr_t  dec_addr;
  route_t dec, route_q, route;
  logic   to_c, to_e;
  logic   addr_fire, resp_fire;

  assign dec_addr = g_ar_valid ? g_ar.addr : g_aw.addr;

  always_comb begin
    if (!g_ar_valid && !g_aw_valid)
      dec = ROUTE_IDLE;
    else if ((dec_addr - clint_base) < CLINT_SIZE)  // wraps below base
      dec = ROUTE_CLINT;
    else
      dec = ROUTE_EXT;
  end

  // latched route wins once the address has gone out
  assign route = (route_q != ROUTE_IDLE) ? route_q : dec;
  assign to_c  = (route == ROUTE_CLINT);
  assign to_e  = (route == ROUTE_EXT);

  assign addr_fire = (g_ar_valid && g_ar_ready) || (g_aw_valid && g_aw_ready);
  assign resp_fire = (g_r_valid && g_r_ready) || (g_b_valid && g_b_ready);

  always_ff @(posedge clock) begin
    if (reset || resp_fire)
      route_q <= ROUTE_IDLE;
    else if (addr_fire)
      route_q <= route;
  end

  assign c_ar_valid = to_c && g_ar_valid;
  assign c_ar       = to_c ? g_ar : '0;
  assign c_r_ready  = to_c && g_r_ready;
  assign c_aw_valid = to_c && g_aw_valid;
  assign c_aw       = to_c ? g_aw : '0;
  assign c_w_valid  = to_c && g_w_valid;
  assign c_w        = to_c ? g_w : '0;
  assign c_b_ready  = to_c && g_b_ready;

  assign e_ar_valid = to_e && g_ar_valid;
  assign e_ar       = to_e ? g_ar : '0;
  assign e_r_ready  = to_e && g_r_ready;
  assign e_aw_valid = to_e && g_aw_valid;
  assign e_aw       = to_e ? g_aw : '0;
  assign e_w_valid  = to_e && g_w_valid;
  assign e_w        = to_e ? g_w : '0;
  assign e_b_ready  = to_e && g_b_ready;

  assign g_ar_ready = (to_c && c_ar_ready) || (to_e && e_ar_ready);
  assign g_r_valid  = (to_c && c_r_valid) || (to_e && e_r_valid);
  assign g_r        = to_c ? c_r : (to_e ? e_r : '0);
  assign g_aw_ready = (to_c && c_aw_ready) || (to_e && e_aw_ready);
  assign g_w_ready  = (to_c && c_w_ready) || (to_e && e_w_ready);
  assign g_b_valid  = (to_c && c_b_valid) || (to_e && e_b_valid);
  assign g_b        = to_c ? c_b : (to_e ? e_b : '0);

  // a response only comes back after its address went out
  a_resp_after_addr: assert property (@(posedge clock) disable iff (reset)
    resp_fire |-> route_q != ROUTE_IDLE);

endmodule

//--- verilog/clint.sv
`timescale 1ns/10ps

module clint #(
  parameter axi_pkg::addr_t clint_base = soc_map_pkg::CLINT_BASE_DEFAULT
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              ar_valid,
  input  axi_pkg::ar_chan_t ar,
  output logic              ar_ready,
  output logic              r_valid,
  output axi_pkg::r_chan_t  r,
  input  logic              r_ready,
  input  logic              aw_valid,
  input  axi_pkg::aw_chan_t aw,
  output logic              aw_ready,
  input  logic              w_valid,
  input  axi_pkg::w_chan_t  w,
  output logic              w_ready,
  output logic              b_valid,
  output axi_pkg::b_chan_t  b,
  input  logic              b_ready
);
  import axi_pkg::*;
  import soc_map_pkg::*;

  typedef logic [63:0] mtime_t;

  mtime_t     mtime;
  data_t      rdata_q;
  logic [7:0] offset;
  logic       idle, ar_fire, wr_fire;

  assign idle     = !r_valid && !b_valid;
  assign ar_ready = idle;
  assign aw_ready = idle;
  assign w_ready  = idle;
  assign ar_fire  = ar_valid && idle;
  assign wr_fire  = aw_valid && w_valid && idle;  // aw and w arrive together

  assign offset = ar.addr[7:0] - clint_base[7:0];

  always_ff @(posedge clock) begin
    if (reset)
      mtime <= '0;
    else
      mtime <= mtime + 64'd1;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire)
        r_valid <= 1'b1;
      else if (r_ready)
        r_valid <= 1'b0;
      if (wr_fire)
        b_valid <= 1'b1;  // mtime is read only
      else if (b_ready)
        b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      case (offset)
        MTIME_LO_OFFSET: rdata_q <= mtime[31:0];
        MTIME_HI_OFFSET: rdata_q <= mtime[63:32];
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign r = '{data: rdata_q, resp: RESP_OKAY};
  assign b = '{resp: RESP_SLVERR};

  // arbiter lets only one transaction through at a time
  a_one_resp: assert property (@(posedge clock) disable iff (reset)
    !(r_valid && b_valid));

endmodule

//--- verilog/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top #(
  parameter axi_pkg::addr_t clint_base = soc_map_pkg::CLINT_BASE_DEFAULT
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              ar_valid_0,
  input  axi_pkg::ar_chan_t ar_0,
  output logic              ar_ready_0,
  output logic              r_valid_0,
  output axi_pkg::r_chan_t  r_0,
  input  logic              r_ready_0,
  input  logic              aw_valid_0,
  input  axi_pkg::aw_chan_t aw_0,
  output logic              aw_ready_0,
  input  logic              w_valid_0,
  input  axi_pkg::w_chan_t  w_0,
  output logic              w_ready_0,
  output logic              b_valid_0,
  output axi_pkg::b_chan_t  b_0,
  input  logic              b_ready_0,
  input  logic              ar_valid_1,
  input  axi_pkg::ar_chan_t ar_1,
  output logic              ar_ready_1,
  output logic              r_valid_1,
  output axi_pkg::r_chan_t  r_1,
  input  logic              r_ready_1,
  input  logic              aw_valid_1,
  input  axi_pkg::aw_chan_t aw_1,
  output logic              aw_ready_1,
  input  logic              w_valid_1,
  input  axi_pkg::w_chan_t  w_1,
  output logic              w_ready_1,
  output logic              b_valid_1,
  output axi_pkg::b_chan_t  b_1,
  input  logic              b_ready_1,
  // external full AXI4 port
  input  logic              io_master_awready,
  output logic              io_master_awvalid,
  output logic [3:0]        io_master_awid,
  output logic [31:0]       io_master_awaddr,
  output logic [7:0]        io_master_awlen,
  output logic [2:0]        io_master_awsize,
  output logic [1:0]        io_master_awburst,
  input  logic              io_master_wready,
  output logic              io_master_wvalid,
  output logic [31:0]       io_master_wdata,
  output logic [3:0]        io_master_wstrb,
  output logic              io_master_wlast,
  output logic              io_master_bready,
  input  logic              io_master_bvalid,
  input  logic [3:0]        io_master_bid,
  input  logic [1:0]        io_master_bresp,
  input  logic              io_master_arready,
  output logic              io_master_arvalid,
  output logic [3:0]        io_master_arid,
  output logic [31:0]       io_master_araddr,
  output logic [7:0]        io_master_arlen,
  output logic [2:0]        io_master_arsize,
  output logic [1:0]        io_master_arburst,
  output logic              io_master_rready,
  input  logic              io_master_rvalid,
  input  logic [3:0]        io_master_rid,
  input  logic [31:0]       io_master_rdata,
  input  logic [1:0]        io_master_rresp,
  input  logic              io_master_rlast
);
  import axi_pkg::*;

  logic     g_ar_valid, g_ar_ready, g_r_valid, g_r_ready;
  logic     g_aw_valid, g_aw_ready, g_w_valid, g_w_ready, g_b_valid, g_b_ready;
  logic     c_ar_valid, c_ar_ready, c_r_valid, c_r_ready;
  logic     c_aw_valid, c_aw_ready, c_w_valid, c_w_ready, c_b_valid, c_b_ready;
  logic     e_ar_valid, e_ar_ready, e_r_valid, e_r_ready;
  logic     e_aw_valid, e_aw_ready, e_w_valid, e_w_ready, e_b_valid, e_b_ready;
  ar_chan_t g_ar, c_ar, e_ar;
  aw_chan_t g_aw, c_aw, e_aw;
  w_chan_t  g_w, c_w, e_w;
  r_chan_t  g_r, c_r, e_r;
  b_chan_t  g_b, c_b, e_b;

  axi_arbiter u_arbiter (.*);

  axi_addr_router #(.clint_base(clint_base)) u_router (.*);

  clint #(.clint_base(clint_base)) u_clint (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (c_ar_valid),
    .ar       (c_ar),
    .ar_ready (c_ar_ready),
    .r_valid  (c_r_valid),
    .r        (c_r),
    .r_ready  (c_r_ready),
    .aw_valid (c_aw_valid),
    .aw       (c_aw),
    .aw_ready (c_aw_ready),
    .w_valid  (c_w_valid),
    .w        (c_w),
    .w_ready  (c_w_ready),
    .b_valid  (c_b_valid),
    .b        (c_b),
    .b_ready  (c_b_ready)
  );

  // single beat only, id 0
  assign io_master_arvalid = e_ar_valid;
  assign io_master_araddr  = e_ar.addr;
  assign io_master_arid    = 4'd0;
  assign io_master_arlen   = 8'd0;
  assign io_master_arsize  = 3'b010;
  assign io_master_arburst = 2'b01;  // INCR
  assign e_ar_ready        = io_master_arready;

  assign io_master_rready = e_r_ready;
  assign e_r_valid        = io_master_rvalid;
  assign e_r              = '{data: io_master_rdata, resp: io_master_rresp};

  assign io_master_awvalid = e_aw_valid;
  assign io_master_awaddr  = e_aw.addr;
  assign io_master_awid    = 4'd0;
  assign io_master_awlen   = 8'd0;
  assign io_master_awsize  = 3'b010;
  assign io_master_awburst = 2'b01;
  assign e_aw_ready        = io_master_awready;

  assign io_master_wvalid = e_w_valid;
  assign io_master_wdata  = e_w.data;
  assign io_master_wstrb  = e_w.strb;
  assign io_master_wlast  = 1'b1;
  assign e_w_ready        = io_master_wready;

  assign io_master_bready = e_b_ready;
  assign e_b_valid        = io_master_bvalid;
  assign e_b              = '{resp: io_master_bresp};

endmodule

//--- verification/axi_slave_model.sv
`timescale 1ns/10ps

module axi_slave_model (
  input  logic        clock,
  input  logic        reset,
  output logic        io_master_awready,
  input  logic        io_master_awvalid,
  input  logic [3:0]  io_master_awid,
  input  logic [31:0] io_master_awaddr,
  input  logic [7:0]  io_master_awlen,
  input  logic [2:0]  io_master_awsize,
  input  logic [1:0]  io_master_awburst,
  output logic        io_master_wready,
  input  logic        io_master_wvalid,
  input  logic [31:0] io_master_wdata,
  input  logic [3:0]  io_master_wstrb,
  input  logic        io_master_wlast,
  input  logic        io_master_bready,
  output logic        io_master_bvalid,
  output logic [3:0]  io_master_bid,
  output logic [1:0]  io_master_bresp,
  output logic        io_master_arready,
  input  logic        io_master_arvalid,
  input  logic [3:0]  io_master_arid,
  input  logic [31:0] io_master_araddr,
  input  logic [7:0]  io_master_arlen,
  input  logic [2:0]  io_master_arsize,
  input  logic [1:0]  io_master_arburst,
  input  logic        io_master_rready,
  output logic        io_master_rvalid,
  output logic [3:0]  io_master_rid,
  output logic [31:0] io_master_rdata,
  output logic [1:0]  io_master_rresp,
  output logic        io_master_rlast
);
  logic [31:0] mem [0:255];  // word addressed by addr[9:2]

  task automatic next_edge;
    @(posedge clock);
    #1;
  endtask

  task automatic serve_read;
    logic [7:0] idx;
    idx = io_master_araddr[9:2];
    repeat ($urandom_range(1, 4)) next_edge();
    io_master_arready = 1'b1;
    next_edge();  // address taken at this edge
    io_master_arready = 1'b0;
    repeat ($urandom_range(0, 3)) next_edge();
    io_master_rvalid = 1'b1;
    io_master_rdata  = mem[idx];
    io_master_rresp  = 2'b00;
    do @(negedge clock); while (!io_master_rready);
    next_edge();
    io_master_rvalid = 1'b0;
    io_master_rdata  = '0;
  endtask

  task automatic serve_write;
    logic [7:0]  idx;
    logic [31:0] word;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    idx   = io_master_awaddr[9:2];
    wdata = io_master_wdata;
    wstrb = io_master_wstrb;
    repeat ($urandom_range(1, 4)) next_edge();
    io_master_awready = 1'b1;
    io_master_wready  = 1'b1;
    next_edge();
    io_master_awready = 1'b0;
    io_master_wready  = 1'b0;
    word = mem[idx];
    for (int b = 0; b < 4; b++)
      if (wstrb[b])
        word[8*b +: 8] = wdata[8*b +: 8];
    mem[idx] = word;
    repeat ($urandom_range(0, 3)) next_edge();
    io_master_bvalid = 1'b1;
    io_master_bresp  = 2'b00;
    do @(negedge clock); while (!io_master_bready);
    next_edge();
    io_master_bvalid = 1'b0;
  endtask

  initial begin
    io_master_awready = 1'b0;
    io_master_wready  = 1'b0;
    io_master_bvalid  = 1'b0;
    io_master_bid     = 4'd0;
    io_master_bresp   = 2'b00;
    io_master_arready = 1'b0;
    io_master_rvalid  = 1'b0;
    io_master_rid     = 4'd0;
    io_master_rdata   = '0;
    io_master_rresp   = 2'b00;
    io_master_rlast   = 1'b1;
    for (int i = 0; i < 256; i++)
      mem[i] = '0;
    forever begin
      @(negedge clock);
      if (!reset && io_master_arvalid)
        serve_read();
      else if (!reset && io_master_awvalid && io_master_wvalid)
        serve_write();
    end
  end

endmodule

//--- verification/soc_bus_tb.sv
`timescale 1ns/10ps

module soc_bus_tb;
  import axi_pkg::*;
  import soc_map_pkg::*;

  localparam int    NUM_TXN  = 200;
  localparam int    TIMEOUT  = 2 * NUM_TXN * 64;  // 64 cycles per transaction of either master
  localparam addr_t EXT_BASE = 32'h8000_0000;

  logic clock = 1'b0;
  logic reset;

  // index is the master id
  logic     ar_valid [2];
  ar_chan_t ar_req   [2];
  logic     aw_valid [2];
  aw_chan_t aw_req   [2];
  logic     w_valid  [2];
  w_chan_t  w_req    [2];
  logic     r_ready  [2];
  logic     b_ready  [2];
  logic     ar_ready [2];
  logic     aw_ready [2];
  logic     w_ready  [2];
  logic     r_valid  [2];
  r_chan_t  r_rsp    [2];
  logic     b_valid  [2];
  b_chan_t  b_rsp    [2];

  logic        io_master_awvalid, io_master_awready, io_master_wvalid, io_master_wready;
  logic        io_master_wlast, io_master_bvalid, io_master_bready;
  logic        io_master_arvalid, io_master_arready, io_master_rvalid, io_master_rready;
  logic        io_master_rlast;
  logic [3:0]  io_master_awid, io_master_wstrb, io_master_bid, io_master_arid, io_master_rid;
  logic [31:0] io_master_awaddr, io_master_wdata, io_master_araddr, io_master_rdata;
  logic [7:0]  io_master_awlen, io_master_arlen;
  logic [2:0]  io_master_awsize, io_master_arsize;
  logic [1:0]  io_master_awburst, io_master_arburst, io_master_bresp, io_master_rresp;

  data_t       shadow [addr_t];  // external memory as the masters wrote it
  logic [63:0] mtime_model = '0;
  int          cycle_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          owner = -1;        // master holding the bus
  int          skipped [2] = '{0, 0};
  logic        addr_fire [2];
  logic        resp_fire [2];

  soc_bus_top DUT (
    .ar_valid_0 (ar_valid[0]), .ar_valid_1 (ar_valid[1]),
    .ar_0       (ar_req[0]),   .ar_1       (ar_req[1]),
    .ar_ready_0 (ar_ready[0]), .ar_ready_1 (ar_ready[1]),
    .r_valid_0  (r_valid[0]),  .r_valid_1  (r_valid[1]),
    .r_0        (r_rsp[0]),    .r_1        (r_rsp[1]),
    .r_ready_0  (r_ready[0]),  .r_ready_1  (r_ready[1]),
    .aw_valid_0 (aw_valid[0]), .aw_valid_1 (aw_valid[1]),
    .aw_0       (aw_req[0]),   .aw_1       (aw_req[1]),
    .aw_ready_0 (aw_ready[0]), .aw_ready_1 (aw_ready[1]),
    .w_valid_0  (w_valid[0]),  .w_valid_1  (w_valid[1]),
    .w_0        (w_req[0]),    .w_1        (w_req[1]),
    .w_ready_0  (w_ready[0]),  .w_ready_1  (w_ready[1]),
    .b_valid_0  (b_valid[0]),  .b_valid_1  (b_valid[1]),
    .b_0        (b_rsp[0]),    .b_1        (b_rsp[1]),
    .b_ready_0  (b_ready[0]),  .b_ready_1  (b_ready[1]),
    .*
  );

  axi_slave_model slave (.*);

  always #2 clock = ~clock;

  // mtime reads 0 in the first cycle with reset low
  always @(posedge clock)
    if (!reset)
      mtime_model <= mtime_model + 64'd1;

  task automatic finish_run(input bit timed_out);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("timeout, traffic still running after %0d cycles", cycle_count);
      finish_run(1'b1);
    end
  end

  task automatic next_cycle;
    @(posedge clock);
    #1;
  endtask

  task automatic compare_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("ERROR %s got %h expected %h at %0t", sig, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  function automatic bit in_clint(input addr_t a);
    return (a >= CLINT_BASE_DEFAULT) && (a < CLINT_BASE_DEFAULT + CLINT_SIZE);
  endfunction

  function automatic data_t shadow_read(input addr_t a);
    return shadow.exists(a) ? shadow[a] : '0;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input w_chan_t wr);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++)
      if (wr.strb[i])
        res[8*i +: 8] = wr.data[8*i +: 8];
    return res;
  endfunction

  task automatic check_fixed_fields;
    compare_value("io_master_arid", io_master_arid, 0);
    compare_value("io_master_arlen", io_master_arlen, 0);
    compare_value("io_master_arsize", io_master_arsize, 2);
    compare_value("io_master_arburst", io_master_arburst, 1);  // INCR
    compare_value("io_master_awid", io_master_awid, 0);
    compare_value("io_master_awlen", io_master_awlen, 0);
    compare_value("io_master_awsize", io_master_awsize, 2);
    compare_value("io_master_awburst", io_master_awburst, 1);
    compare_value("io_master_wlast", io_master_wlast, 1);
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 2; i++) begin
        addr_fire[i] = (ar_valid[i] && ar_ready[i]) || (aw_valid[i] && aw_ready[i]);
        resp_fire[i] = (r_valid[i] && r_ready[i]) || (b_valid[i] && b_ready[i]);
      end
      for (int i = 0; i < 2; i++) begin
        if (addr_fire[i]) begin
          assert (owner < 0)
          else report_failure($sformatf("master %0d started while master %0d held the bus",
                                        i, owner));
          owner      = i;
          skipped[i] = 0;
        end else if (addr_fire[1 - i] && (ar_valid[i] || aw_valid[i])) begin
          skipped[i]++;
          assert (skipped[i] <= 1)
          else report_failure($sformatf("master %0d passed over twice in a row", i));
        end
      end
      for (int i = 0; i < 2; i++)
        if (resp_fire[i])
          owner = -1;
      check_fixed_fields();
      assert (!(io_master_arvalid && in_clint(io_master_araddr)) &&
              !(io_master_awvalid && in_clint(io_master_awaddr)))
      else report_failure("CLINT access showed up on the external port");
    end
  end

  task automatic send_read(input int m, input addr_t addr, output logic [63:0] t_ar);
    ar_req[m]   = '{addr: addr};
    ar_valid[m] = 1'b1;
    do @(negedge clock); while (!ar_ready[m]);
    t_ar = mtime_model;  // counter in the transfer cycle
    next_cycle();
    ar_valid[m] = 1'b0;
  endtask

  task automatic send_write(input int m, input addr_t addr, input w_chan_t wr);
    logic fire_aw;
    logic fire_w;
    aw_req[m]   = '{addr: addr};
    w_req[m]    = wr;
    aw_valid[m] = 1'b1;
    w_valid[m]  = 1'b1;
    while (aw_valid[m] || w_valid[m]) begin
      @(negedge clock);
      fire_aw = aw_valid[m] && aw_ready[m];
      fire_w  = w_valid[m] && w_ready[m];
      next_cycle();
      if (fire_aw)
        aw_valid[m] = 1'b0;
      if (fire_w)
        w_valid[m] = 1'b0;
    end
  endtask

  // rready held low a few cycles while the payload stays put
  task automatic take_read_response(input int m, output r_chan_t rsp);
    r_chan_t held;
    do @(negedge clock); while (!r_valid[m]);
    held = r_rsp[m];
    repeat ($urandom_range(0, 3)) begin
      next_cycle();
      @(negedge clock);
      assert (r_valid[m])
      else report_failure($sformatf("rvalid of master %0d dropped before rready", m));
      compare_value($sformatf("r_%0d.data", m), r_rsp[m].data, held.data);
      compare_value($sformatf("r_%0d.resp", m), r_rsp[m].resp, held.resp);
    end
    next_cycle();
    r_ready[m] = 1'b1;
    @(negedge clock);
    next_cycle();
    r_ready[m] = 1'b0;
    rsp = held;
  endtask

  task automatic take_write_response(input int m, output b_chan_t rsp);
    b_chan_t held;
    do @(negedge clock); while (!b_valid[m]);
    held = b_rsp[m];
    repeat ($urandom_range(0, 3)) begin
      next_cycle();
      @(negedge clock);
      assert (b_valid[m])
      else report_failure($sformatf("bvalid of master %0d dropped before bready", m));
      compare_value($sformatf("b_%0d.resp", m), b_rsp[m].resp, held.resp);
    end
    next_cycle();
    b_ready[m] = 1'b1;
    @(negedge clock);
    next_cycle();
    b_ready[m] = 1'b0;
    rsp = held;
  endtask

  task automatic run_master(input int m);
    int          kind;
    bit          hi;
    addr_t       addr;
    w_chan_t     wr;
    r_chan_t     rsp;
    b_chan_t     brsp;
    logic [63:0] t_ar;
    data_t       exp;
    for (int n = 0; n < NUM_TXN; n++) begin
      repeat ($urandom_range(0, 4)) next_cycle();
      kind    = $urandom_range(0, 3);
      wr.data = $urandom();
      wr.strb = $urandom_range(0, 15);
      case (kind)
        0: begin
          addr = EXT_BASE + ($urandom_range(0, 63) << 2);
          send_read(m, addr, t_ar);
          exp = shadow_read(addr);
          take_read_response(m, rsp);
          compare_value($sformatf("r_%0d.data", m), rsp.data, exp);
          compare_value($sformatf("r_%0d.resp", m), rsp.resp, RESP_OKAY);
        end
        1: begin
          addr = EXT_BASE + ($urandom_range(0, 63) << 2);
          send_write(m, addr, wr);
          take_write_response(m, brsp);
          compare_value($sformatf("b_%0d.resp", m), brsp.resp, RESP_OKAY);
          shadow[addr] = merge_bytes(shadow_read(addr), wr);
        end
        2: begin  // mtime
          hi   = $urandom_range(0, 1);
          addr = CLINT_BASE_DEFAULT + (hi ? MTIME_HI_OFFSET : MTIME_LO_OFFSET);
          send_read(m, addr, t_ar);
          take_read_response(m, rsp);
          exp = hi ? t_ar[63:32] : t_ar[31:0];
          compare_value($sformatf("r_%0d.data", m), rsp.data, exp);
          compare_value($sformatf("r_%0d.resp", m), rsp.resp, RESP_OKAY);
        end
        default: begin
          addr = CLINT_BASE_DEFAULT + ($urandom_range(0, 63) << 2);
          send_write(m, addr, wr);
          take_write_response(m, brsp);
          compare_value($sformatf("b_%0d.resp", m), brsp.resp, RESP_SLVERR);
        end
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'hb32ed58d));
    reset = 1'b1;
    for (int i = 0; i < 2; i++) begin
      ar_valid[i] = 1'b0;
      ar_req[i]   = '0;
      aw_valid[i] = 1'b0;
      aw_req[i]   = '0;
      w_valid[i]  = 1'b0;
      w_req[i]    = '0;
      r_ready[i]  = 1'b0;
      b_ready[i]  = 1'b0;
    end
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    fork
      run_master(0);
      run_master(1);
    join
    repeat (4) next_cycle();
    finish_run(1'b0);
  end

endmodule

//--- verilog.f
verilog/axi_pkg.sv
verilog/soc_map_pkg.sv
verilog/axi_arbiter.sv
verilog/axi_addr_router.sv
verilog/clint.sv
verilog/soc_bus_top.sv
verification/axi_slave_model.sv
verification/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - target: any(rtl, test)
    files:
      - verilog/axi_pkg.sv
      - verilog/soc_map_pkg.sv
      - verilog/axi_arbiter.sv
      - verilog/axi_addr_router.sv
      - verilog/clint.sv
      - verilog/soc_bus_top.sv
  - target: test
    files:
      - verification/axi_slave_model.sv
      - verification/soc_bus_tb.sv
